// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path and pc width
`define XLEN 32

// Register address width and number of architectural registers
`define REG_ADDR_W 5
`define NUM_REGS 32

`endif

// ==== rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JUMP // JAL and JALR, always taken
    } branch_op_e;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_PC,
        OPA_ZERO
    } opa_sel_e;

    typedef enum logic {
        OPB_RS2,
        OPB_IMM
    } opb_sel_e;

    typedef enum logic {
        WB_ALU,
        WB_LINK // pc+4
    } wb_sel_e;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [31:0]       instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1_addr;
        logic [`REG_ADDR_W-1:0] rs2_addr;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        alu_op_e                alu_op;
        opa_sel_e               opa_sel;
        opb_sel_e               opb_sel;
        branch_op_e             branch_op;
        logic                   jalr;
        logic                   reg_write_en;
        wb_sel_e                wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_write_en;
        logic [`XLEN-1:0]       result;
    } ex_wb_t;

    localparam if_id_t IF_ID_BUBBLE = '{valid: 1'b0, pc: '0, instr: NOP_INSTR};

    localparam id_ex_t ID_EX_BUBBLE = '{
        valid:        1'b0,
        pc:           '0,
        rd:           '0,
        rs1_addr:     '0,
        rs2_addr:     '0,
        rs1_data:     '0,
        rs2_data:     '0,
        imm:          '0,
        alu_op:       ALU_ADD,
        opa_sel:      OPA_ZERO,
        opb_sel:      OPB_RS2,
        branch_op:    BR_NONE,
        jalr:         1'b0,
        reg_write_en: 1'b0,
        wb_sel:       WB_ALU
    };

    localparam ex_wb_t EX_WB_BUBBLE = '{valid: 1'b0, rd: '0, reg_write_en: 1'b0, result: '0};

endpackage

// ==== pipe_reg.sv ====
// Stage register shared by IF/ID, ID/EX and EX/WB
module pipe_reg #(
    parameter type payload_t = logic,
    parameter payload_t bubble = '0
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= bubble; // Squashed slot carries no architectural effect
        end else begin
            q <= d;
        end
    end

endmodule

// ==== instr_decoder.sv ====
`include "rv_defines.svh"

module instr_decoder import rv_pkg::*; (
    input  if_id_t                 if_id,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    output id_ex_t                 id_ex
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       imm_b;
    logic [`XLEN-1:0]       imm_j;
    logic                   legal;
    logic                   writes;

    assign opcode   = if_id.instr[6:0];
    assign rd       = if_id.instr[11:7];
    assign funct3   = if_id.instr[14:12];
    assign rs1_addr = if_id.instr[19:15];
    assign rs2_addr = if_id.instr[24:20];
    assign funct7   = if_id.instr[31:25];

    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_u = {if_id.instr[31:12], 12'b0};
    assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                    if_id.instr[30:25], if_id.instr[11:8], 1'b0};
    assign imm_j = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
                    if_id.instr[20], if_id.instr[30:21], 1'b0};

    // Shared funct3 map of OP and OP-IMM, alt picks SUB or SRA
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        legal           = 1'b1;
        writes          = 1'b1;
        id_ex.imm       = imm_i;
        id_ex.alu_op    = ALU_ADD;
        id_ex.opa_sel   = OPA_RS1;
        id_ex.opb_sel   = OPB_IMM;
        id_ex.branch_op = BR_NONE;
        id_ex.jalr      = 1'b0;
        id_ex.wb_sel    = WB_ALU;

        case (opcode)
            OPC_OP: begin
                id_ex.opb_sel = OPB_RS2;
                id_ex.alu_op  = alu_from_funct3(funct3, funct7[5]);
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                id_ex.alu_op = alu_from_funct3(funct3, funct7[5] && funct3 == 3'b101);
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end
            end
            OPC_LUI: begin
                id_ex.imm     = imm_u;
                id_ex.opa_sel = OPA_ZERO;
                id_ex.alu_op  = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                id_ex.imm     = imm_u;
                id_ex.opa_sel = OPA_PC;
            end
            OPC_JAL: begin
                id_ex.imm       = imm_j;
                id_ex.opa_sel   = OPA_PC; // ALU forms the jump target
                id_ex.branch_op = BR_JUMP;
                id_ex.wb_sel    = WB_LINK;
            end
            OPC_JALR: begin
                id_ex.branch_op = BR_JUMP;
                id_ex.jalr      = 1'b1;
                id_ex.wb_sel    = WB_LINK;
                legal = (funct3 == 3'b000);
            end
            OPC_BRANCH: begin
                id_ex.imm     = imm_b;
                id_ex.opa_sel = OPA_PC;
                writes        = 1'b0;
                case (funct3)
                    3'b000:  id_ex.branch_op = BR_EQ;
                    3'b001:  id_ex.branch_op = BR_NE;
                    3'b100:  id_ex.branch_op = BR_LT;
                    3'b101:  id_ex.branch_op = BR_GE;
                    3'b110:  id_ex.branch_op = BR_LTU;
                    3'b111:  id_ex.branch_op = BR_GEU;
                    default: legal = 1'b0;
                endcase
            end
            default: begin
                legal  = 1'b0;
                writes = 1'b0;
            end
        endcase

        id_ex.valid        = if_id.valid && legal;
        id_ex.reg_write_en = id_ex.valid && writes && (rd != '0); // x0 is never written
        id_ex.pc           = if_id.pc;
        id_ex.rd           = rd;
        id_ex.rs1_addr     = rs1_addr;
        id_ex.rs2_addr     = rs2_addr;
        id_ex.rs1_data     = rs1_data;
        id_ex.rs2_data     = rs2_data;
    end

endmodule

// ==== reg_file.sv ====
`include "rv_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2
);

    logic [`XLEN-1:0] regs [1:`NUM_REGS-1]; // No storage behind x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so decode sees a result retiring in the same cycle
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && raddr1 == waddr) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (we && raddr2 == waddr) ? wdata : regs[raddr2];

endmodule

// ==== exec_unit.sv ====
`include "rv_defines.svh"

module exec_unit import rv_pkg::*; (
    input  id_ex_t           id_ex,
    input  ex_wb_t           ex_wb_prev,
    output logic             redirect_valid,
    output logic [`XLEN-1:0] redirect_pc,
    output ex_wb_t           ex_wb
);

    logic             prev_writes;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] link_addr;
    logic             taken;

    // The instruction one ahead has its result only in EX/WB
    assign prev_writes = ex_wb_prev.valid && ex_wb_prev.reg_write_en && (ex_wb_prev.rd != '0);

    assign rs1_val = (prev_writes && ex_wb_prev.rd == id_ex.rs1_addr) ?
                     ex_wb_prev.result : id_ex.rs1_data;
    assign rs2_val = (prev_writes && ex_wb_prev.rd == id_ex.rs2_addr) ?
                     ex_wb_prev.result : id_ex.rs2_data;

    always_comb begin
        case (id_ex.opa_sel)
            OPA_RS1: op_a = rs1_val;
            OPA_PC:  op_a = id_ex.pc;
            default: op_a = '0;
        endcase
    end

    assign op_b  = (id_ex.opb_sel == OPB_IMM) ? id_ex.imm : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_b; // Pass B for LUI
        endcase
    end

    // Compare always sees the forwarded register values
    always_comb begin
        case (id_ex.branch_op)
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_NE:   taken = (rs1_val != rs2_val);
            BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  taken = (rs1_val < rs2_val);
            BR_GEU:  taken = (rs1_val >= rs2_val);
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Control transfers compute their target in the ALU
    assign redirect_valid = id_ex.valid && taken;
    assign redirect_pc    = id_ex.jalr ? {alu_result[`XLEN-1:1], 1'b0} : alu_result;

    assign link_addr = id_ex.pc + `XLEN'd4;

    always_comb begin
        ex_wb.valid        = id_ex.valid;
        ex_wb.rd           = id_ex.rd;
        ex_wb.reg_write_en = id_ex.reg_write_en;
        ex_wb.result       = (id_ex.wb_sel == WB_LINK) ? link_addr : alu_result;
    end

endmodule

// ==== rv_core_top.sv ====
`include "rv_defines.svh"

module rv_core_top import rv_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   fetch_valid,
    input  logic [`XLEN-1:0]       fetch_pc,
    input  logic [31:0]            fetch_instr,
    output logic                   redirect_valid,
    output logic [`XLEN-1:0]       redirect_pc,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data
);

    if_id_t                 if_id_d;
    if_id_t                 if_id_q;
    id_ex_t                 id_ex_d;
    id_ex_t                 id_ex_q;
    ex_wb_t                 ex_wb_d;
    ex_wb_t                 ex_wb_q;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   rf_we;

    assign if_id_d = '{valid: fetch_valid, pc: fetch_pc, instr: fetch_instr};

    // A taken transfer squashes decode and the fetch of the same cycle
    pipe_reg #(.payload_t(if_id_t), .bubble(IF_ID_BUBBLE)) u_if_id (
        .clk   (clk),
        .reset (reset),
        .flush (redirect_valid),
        .d     (if_id_d),
        .q     (if_id_q)
    );

    instr_decoder u_decoder (
        .if_id    (if_id_q),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .id_ex    (id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t), .bubble(ID_EX_BUBBLE)) u_id_ex (
        .clk   (clk),
        .reset (reset),
        .flush (redirect_valid),
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    exec_unit u_exec (
        .id_ex          (id_ex_q),
        .ex_wb_prev     (ex_wb_q),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ex_wb          (ex_wb_d)
    );

    // The jump itself retires here since it may write the link
    pipe_reg #(.payload_t(ex_wb_t), .bubble(EX_WB_BUBBLE)) u_ex_wb (
        .clk   (clk),
        .reset (reset),
        .flush (1'b0),
        .d     (ex_wb_d),
        .q     (ex_wb_q)
    );

    assign rf_we = ex_wb_q.valid && ex_wb_q.reg_write_en;

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .we     (rf_we),
        .waddr  (ex_wb_q.rd),
        .wdata  (ex_wb_q.result),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    assign wb_valid = rf_we; // Branches and x0 targets stay off the port
    assign wb_rd    = ex_wb_q.rd;
    assign wb_data  = ex_wb_q.result;

endmodule

// ==== rv_core_props.sv ====
`include "rv_defines.svh"

module rv_core_props (
    input logic                   clk,
    input logic                   reset,
    input logic                   wb_valid,
    input logic [`REG_ADDR_W-1:0] wb_rd,
    input logic                   redirect_valid,
    input logic [`XLEN-1:0]       redirect_pc
);

    // All stage registers hold bubbles right after a reset edge
    quiet_after_reset: assert property (
        @(posedge clk) $past(reset) |-> (!wb_valid && !redirect_valid))
        else $error("Writeback or redirect active in the cycle after reset");

    no_x0_writeback: assert property (
        @(posedge clk) disable iff (reset) wb_valid |-> (wb_rd != '0))
        else $error("A writeback to x0 reached the port");

    aligned_redirect: assert property (
        @(posedge clk) disable iff (reset) redirect_valid |-> (redirect_pc[1:0] == 2'b00))
        else $error("Redirect target is not word aligned");

endmodule

bind rv_core_top rv_core_props u_props (
    .clk            (clk),
    .reset          (reset),
    .wb_valid       (wb_valid),
    .wb_rd          (wb_rd),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
);

// ==== rv_core_tb.sv ====
`include "rv_defines.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int MEM_WORDS  = 256;
    localparam int MEM_BYTES  = MEM_WORDS * 4;
    localparam int WB_TARGET  = 2000;
    localparam int MAX_CYCLES = 20000;
    localparam int IDLE_LIMIT = 300;
    localparam int STEP_LIMIT = 512;

    logic                   clk;
    logic                   reset;
    logic                   fetch_valid;
    logic [`XLEN-1:0]       fetch_pc;
    logic [31:0]            fetch_instr;
    logic                   redirect_valid;
    logic [`XLEN-1:0]       redirect_pc;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    logic [31:0]      mem [0:MEM_WORDS-1];
    logic [`XLEN-1:0] model_regs [0:`NUM_REGS-1];
    logic [`XLEN-1:0] model_pc;
    logic [`XLEN-1:0] fetch_ptr;
    logic [`XLEN-1:0] redirect_target;
    logic             redirect_seen;
    ex_wb_t           exp_wb_q[$];
    logic [`XLEN-1:0] exp_target_q[$];
    int               n_wb;
    int               n_redirect;
    int               edges_since_reset;
    int               idle;
    int               past_end;
    int               cycles;

    rv_core_top u_dut (
        .clk            (clk),
        .reset          (reset),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // Registers x0..x7 only, so dependencies at short distances are common
    function automatic logic [31:0] random_instr(input int idx);
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [20:0] off;
        int          kind;
        int          tgt;
        r    = $urandom;
        kind = int'($urandom % 100);
        rd   = {2'b00, r[2:0]};
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        f3   = r[11:9];
        off  = {16'd0, r[15:13], 2'b00} + 21'd4; // Forward only, so every program ends
        tgt  = (idx + 1 + int'(r[15:13])) * 4 + int'(r[16]);
        if (kind < 28) begin
            return {(r[12] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
        end else if (kind < 54) begin
            imm = r[31:20];
            if (f3 == 3'd1) begin
                imm[11:5] = 7'h00;
            end else if (f3 == 3'd5) begin
                imm[11:5] = r[12] ? 7'h20 : 7'h00;
            end
            return {imm, rs1, f3, rd, OPC_OP_IMM};
        end else if (kind < 62) begin
            return {r[31:12], rd, OPC_LUI};
        end else if (kind < 68) begin
            return {r[31:12], rd, OPC_AUIPC};
        end else if (kind < 82) begin
            if (f3 == 3'd2 || f3 == 3'd3) begin
                f3 = f3 + 3'd2;
            end
            return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
        end else if (kind < 88) begin
            return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
        end else if (kind < 94) begin
            imm = tgt[11:0]; // Absolute target from x0, odd values test the cleared bit 0
            return {imm, 5'd0, 3'b000, rd, OPC_JALR};
        end
        case (r[10:9])
            2'd0:    return {r[31:7], 7'b0000011};
            2'd1:    return {7'h01, r[24:7], OPC_OP};
            default: return {r[31:15], 3'b010, r[11:7], OPC_BRANCH};
        endcase
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = random_instr(i);
        end
    endtask

    function automatic logic [`XLEN-1:0] int_op(input logic [2:0] f3, input logic alt,
                                                input logic [`XLEN-1:0] a,
                                                input logic [`XLEN-1:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // One instruction of the sequential ISA model
    task automatic step_model();
        logic [31:0]      ins;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm_i;
        logic [`XLEN-1:0] res;
        logic [`XLEN-1:0] target;
        logic             legal;
        logic             writes;
        logic             taken;
        ex_wb_t           wb;
        ins    = mem[model_pc[9:2]];
        f3     = ins[14:12];
        f7     = ins[31:25];
        a      = model_regs[ins[19:15]];
        b      = model_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        legal  = 1'b1;
        writes = 1'b1;
        taken  = 1'b0;
        res    = '0;
        target = '0;
        case (ins[6:0])
            OPC_OP: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                res   = int_op(f3, f7[5], a, b);
            end
            OPC_OP_IMM: begin
                legal = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20);
                res   = int_op(f3, f3 == 3'd5 && f7[5], a, imm_i);
            end
            OPC_LUI:   res = {ins[31:12], 12'h000};
            OPC_AUIPC: res = model_pc + {ins[31:12], 12'h000};
            OPC_JAL: begin
                taken  = 1'b1;
                res    = model_pc + 32'd4;
                target = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                legal  = (f3 == 3'd0);
                taken  = 1'b1;
                res    = model_pc + 32'd4;
                target = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                writes = 1'b0;
                target = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                case (f3)
                    3'd0:    taken = (a == b);
                    3'd1:    taken = (a != b);
                    3'd4:    taken = ($signed(a) < $signed(b));
                    3'd5:    taken = ($signed(a) >= $signed(b));
                    3'd6:    taken = (a < b);
                    3'd7:    taken = (a >= b);
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
        if (legal && writes && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = res;
            wb = '{valid: 1'b1, rd: ins[11:7], reg_write_en: 1'b1, result: res};
            exp_wb_q.push_back(wb);
        end
        if (legal && taken) begin
            exp_target_q.push_back(target);
        end
        model_pc = (legal && taken) ? target : model_pc + 32'd4;
    endtask

    task automatic run_model_until(input logic want_wb);
        int steps;
        steps = 0;
        while ((want_wb ? exp_wb_q.size() == 0 : exp_target_q.size() == 0) &&
               model_pc < MEM_BYTES && steps < STEP_LIMIT) begin
            step_model();
            steps++;
        end
    endtask

    task automatic check_writeback(input ex_wb_t expected, input logic [`REG_ADDR_W-1:0] rd,
                                   input logic [`XLEN-1:0] data);
        if (rd !== expected.rd) begin
            stop_with_error($sformatf("Mismatch at %0t: wb_rd expected x%0d, got x%0d",
                                      $time, expected.rd, rd));
        end else if (data !== expected.result) begin
            stop_with_error($sformatf("Mismatch at %0t: wb_data of x%0d expected 0x%08h, got 0x%08h",
                                      $time, rd, expected.result, data));
        end
    endtask

    task automatic check_redirect(input logic [`XLEN-1:0] expected, input logic [`XLEN-1:0] got);
        if (got !== expected) begin
            stop_with_error($sformatf("Mismatch at %0t: redirect_pc expected 0x%08h, got 0x%08h",
                                      $time, expected, got));
        end
    endtask

    // Outputs settle after the rising edge, so the falling edge is a safe sample point
    task automatic sample_outputs();
        ex_wb_t           exp_wb;
        logic [`XLEN-1:0] exp_target;
        if (wb_valid && edges_since_reset < 3) begin
            stop_with_error("Writeback appeared before an instruction could reach EX/WB after reset");
        end else if (redirect_valid && edges_since_reset < 2) begin
            stop_with_error("Redirect appeared before an instruction could reach ID/EX after reset");
        end
        if (wb_valid) begin
            run_model_until(1'b1);
            if (exp_wb_q.size() == 0) begin
                stop_with_error("DUT wrote back a result that the model never produced");
            end else begin
                exp_wb = exp_wb_q.pop_front();
                check_writeback(exp_wb, wb_rd, wb_data);
                n_wb++;
            end
        end
        if (redirect_valid) begin
            run_model_until(1'b0);
            if (exp_target_q.size() == 0) begin
                stop_with_error("DUT redirected where the model took no branch or jump");
            end else begin
                exp_target = exp_target_q.pop_front();
                check_redirect(exp_target, redirect_pc);
                n_redirect++;
            end
        end
        idle = (wb_valid || redirect_valid) ? 0 : idle + 1;
        if (idle > IDLE_LIMIT) begin
            stop_with_error("No writeback or redirect seen for too many cycles");
        end
        redirect_seen   = redirect_valid;
        redirect_target = redirect_pc;
    endtask

    task automatic drive_fetch();
        fetch_pc = fetch_ptr;
        if (fetch_ptr < MEM_BYTES) begin
            fetch_valid = 1'b1;
            fetch_instr = mem[fetch_ptr[9:2]];
        end else begin
            fetch_valid = 1'b0; // Past the end of memory the pipeline drains
            fetch_instr = NOP_INSTR;
        end
    endtask

    task automatic apply_reset();
        reset       = 1'b1;
        fetch_valid = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        model_pc = '0;
        exp_wb_q.delete();
        exp_target_q.delete();
        fetch_ptr         = '0;
        redirect_seen     = 1'b0;
        edges_since_reset = 0;
        idle              = 0;
        past_end          = 0;
        drive_fetch();
    endtask

    // Once the DUT has drained, the model must have nothing left to show
    task automatic restart_program();
        int steps;
        steps = 0;
        while (model_pc < MEM_BYTES && steps < STEP_LIMIT) begin
            step_model();
            steps++;
        end
        if (model_pc < MEM_BYTES) begin
            stop_with_error("Model did not reach the end of the program");
        end else if (exp_wb_q.size() != 0) begin
            stop_with_error("An expected writeback never appeared before the program ended");
        end else if (exp_target_q.size() != 0) begin
            stop_with_error("An expected redirect never appeared before the program ended");
        end else begin
            fill_memory();
            apply_reset();
        end
    endtask

    task automatic advance_fetch();
        if (redirect_seen) begin
            fetch_ptr = redirect_target;
            past_end  = 0;
        end else if (fetch_ptr < MEM_BYTES) begin
            fetch_ptr = fetch_ptr + 32'd4;
        end else begin
            past_end++;
        end
        // The last word needs three edges past acceptance and one sample to show on wb
        if (past_end >= 4) begin
            restart_program();
        end else begin
            drive_fetch();
        end
    endtask

    initial begin
        void'($urandom(35));
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_instr = NOP_INSTR;
        n_wb        = 0;
        n_redirect  = 0;
        cycles      = 0;
        fill_memory();
        apply_reset();
        while (n_wb < WB_TARGET && cycles < MAX_CYCLES) begin
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
            #1;
            cycles++;
            edges_since_reset++;
            advance_fetch();
        end
        if (n_wb < WB_TARGET) begin
            stop_with_error("Cycle limit reached before enough writebacks were checked");
        end else if (n_redirect == 0) begin
            stop_with_error("No redirect was seen during the whole run");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+.
rv_pkg.sv
pipe_reg.sv
instr_decoder.sv
reg_file.sv
exec_unit.sv
rv_core_top.sv
rv_core_props.sv
rv_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = rv_core_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)
